//--- Bender.yml
package:
  name: rp_drive_regs

sources:
  - files:
      - design/rpPkg.sv
      - design/rpWishboneSlave.sv
      - design/rpCommandDecode.sv
      - design/rpOffsetReg.sv
      - design/rpDriveSequencer.sv
      - design/rpDriveRegs.sv
  - target: test
    files:
      - verification/rpDriveRegsAsserts.sv
      - verification/rpDriveRegsTb.sv

//--- design/rpCommandDecode.sv
/*
   Turns a GO write into one registered command strobe.
   Strobe appears the cycle after the write edge.
   GO writes while the drive is busy and unknown codes are dropped.
*/

`timescale 1ns/1ns
`default_nettype none

module rpCommandDecode (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 goWrite,
   input  wire rpPkg::rpFunc_t func,
   input  wire                 dry,
   output rpPkg::rpCmd_t       cmd
);

   rpPkg::rpCmd_t decoded;   // Strobe selected by this cycle's write

   //////////////////////////////////////////////////////////////////////
   // Function decode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      decoded = '0;
      // Only a GO write to a ready drive issues anything
      if (goWrite && dry)
      begin
         case (func)
            rpPkg::funcDriveClear:
               decoded.driveClear = 1'b1;
            rpPkg::funcCenter:
               decoded.center = 1'b1;
            rpPkg::funcPreset:
               decoded.preset = 1'b1;
            rpPkg::funcSeek:
               decoded.seek = 1'b1;
            rpPkg::funcRecal:
               decoded.recal = 1'b1;
            rpPkg::funcWrite:
               decoded.write = 1'b1;
            rpPkg::funcWriteHeader:
               decoded.writeHeader = 1'b1;
            // Everything else is a no-op here
            default:
               decoded = '0;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Strobe register
   //////////////////////////////////////////////////////////////////////

   // At most one strobe high, for one cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         cmd <= '0;
      else
         cmd <= decoded;
   end

endmodule

`default_nettype wire

//--- design/rpDriveRegs.sv
/*
   RP drive register block, top level.
   Wishbone classic slave with five drive registers.
   seekTime sets the busy length of positioning commands.
*/

`timescale 1ns/1ns
`default_nettype none

module rpDriveRegs #(
   parameter int seekTime = 16
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire rpPkg::rpWbReq_t wbReq,
   output logic                 ack,
   output rpPkg::rpData_t       datOut
);

   // Slave to offset register and decoder
   logic           ofWrite;
   logic           goWrite;
   rpPkg::rpFunc_t func;
   rpPkg::rpReg_t  wrData;
   // Shared drive state
   rpPkg::rpCmd_t  cmd;
   logic           dry;
   rpPkg::rpReg_t  ofValue;

   //////////////////////////////////////////////////////////////////////
   // Bus side
   //////////////////////////////////////////////////////////////////////

   rpWishboneSlave wbSlave_i (
      .clk     (clk),
      .rst     (rst),
      .wbReq   (wbReq),
      .ack     (ack),
      .datOut  (datOut),
      .ofWrite (ofWrite),
      .goWrite (goWrite),
      .func    (func),
      .wrData  (wrData),
      .dry     (dry),
      .ofValue (ofValue)
   );

   //////////////////////////////////////////////////////////////////////
   // Drive side
   //////////////////////////////////////////////////////////////////////

   rpCommandDecode cmdDecode_i (
      .clk     (clk),
      .rst     (rst),
      .goWrite (goWrite),
      .func    (func),
      .dry     (dry),
      .cmd     (cmd)
   );

   rpOffsetReg offsetReg_i (
      .clk     (clk),
      .rst     (rst),
      .ofWrite (ofWrite),
      .wrData  (wrData),
      .cmd     (cmd),
      .dry     (dry),
      .ofValue (ofValue)
   );

   rpDriveSequencer #(
      .seekTime (seekTime)
   ) sequencer_i (
      .clk (clk),
      .rst (rst),
      .cmd (cmd),
      .dry (dry)
   );

endmodule

`default_nettype wire

//--- design/rpDriveSequencer.sv
/*
   Drive-ready sequencer. Positioning and write commands hold the
   drive busy for seekTime cycles (seekTime of 2 or more).
   Preset and drive clear never make the drive busy.
*/

`timescale 1ns/1ns
`default_nettype none

module rpDriveSequencer #(
   parameter int seekTime = 16
) (
   input  wire                clk,
   input  wire                rst,
   input  wire rpPkg::rpCmd_t cmd,
   output logic               dry
);

   localparam int cntWidth = $clog2(seekTime);

   typedef enum logic {
      stReady,
      stBusy
   } seqState_t;

   seqState_t           state;
   logic [cntWidth-1:0] busyCount;   // Cycles left minus one
   logic                startBusy;

   //////////////////////////////////////////////////////////////////////
   // Command qualification
   //////////////////////////////////////////////////////////////////////

   // Commands that move the heads or start a write
   assign startBusy = cmd.seek | cmd.recal | cmd.center
                      | cmd.write | cmd.writeHeader;

   //////////////////////////////////////////////////////////////////////
   // State machine and busy timer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state     <= stReady;
         busyCount <= '0;
      end
      else
      begin
         case (state)
            stReady:
               if (startBusy)
               begin
                  state     <= stBusy;
                  busyCount <= cntWidth'(seekTime - 1);
               end
            stBusy:
               // Last busy cycle when the count reaches zero
               if (busyCount == '0)
                  state <= stReady;
               else
                  busyCount <= busyCount - 1'b1;
            default:
               state <= stReady;
         endcase
      end
   end

   assign dry = (state == stReady);

endmodule

`default_nettype wire

//--- design/rpOffsetReg.sv
/*
   Offset register (RPOF). Written only while the drive is ready.
   Head offset is stored but drives no hardware.
   Unimplemented bits read zero.
*/

`timescale 1ns/1ns
`default_nettype none

module rpOffsetReg (
   input  wire                clk,
   input  wire                rst,
   input  wire                ofWrite,
   input  wire rpPkg::rpReg_t wrData,
   input  wire rpPkg::rpCmd_t cmd,
   input  wire                dry,
   output rpPkg::rpReg_t      ofValue
);

   logic                          fmt22;
   logic                          eci;
   logic                          hci;
   logic                          ofd;
   logic [rpPkg::ofOfsWidth-1:0]  ofs;
   logic                          loadEnable;
   logic                          clearOffset;

   assign loadEnable  = ofWrite & dry;
   // Recal leaves the offset alone
   assign clearOffset = cmd.driveClear | cmd.center | cmd.seek
                        | cmd.write | cmd.writeHeader;

   // Format and inhibit bits, cleared by preset
   always_ff @(posedge clk)
   begin
      if (rst || cmd.preset)
      begin
         fmt22 <= 1'b0;
         eci   <= 1'b0;
         hci   <= 1'b0;
      end
      else if (loadEnable)
      begin
         fmt22 <= wrData[rpPkg::ofFmt22Bit];
         eci   <= wrData[rpPkg::ofEciBit];
         hci   <= wrData[rpPkg::ofHciBit];
      end
   end

   // Offset direction and magnitude
   always_ff @(posedge clk)
   begin
      if (rst || clearOffset)
      begin
         ofd <= 1'b0;
         ofs <= '0;
      end
      else if (loadEnable)
      begin
         ofd <= wrData[rpPkg::ofOfdBit];
         ofs <= wrData[rpPkg::ofOfsLsb +: rpPkg::ofOfsWidth];
      end
   end

   always_comb
   begin
      ofValue = '0;
      ofValue[rpPkg::ofFmt22Bit] = fmt22;
      ofValue[rpPkg::ofEciBit]   = eci;
      ofValue[rpPkg::ofHciBit]   = hci;
      ofValue[rpPkg::ofOfdBit]   = ofd;
      ofValue[rpPkg::ofOfsLsb +: rpPkg::ofOfsWidth] = ofs;
   end

endmodule

`default_nettype wire

//--- design/rpPkg.sv
/*
   Shared widths, register numbers, function codes and bus structs
   for the RP drive register block. Only the low 16 bits of the
   36-bit bus word carry register data.
*/

`default_nettype none

package rpPkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   localparam int dataWidth = 36;
   localparam int regWidth  = 16;
   localparam int selWidth  = 5;
   localparam int funcWidth = 5;

   // Bus word, drive register, register number, function code
   typedef logic [dataWidth-1:0] rpData_t;
   typedef logic [regWidth-1:0]  rpReg_t;
   typedef logic [selWidth-1:0]  rpRegSel_t;
   typedef logic [funcWidth-1:0] rpFunc_t;

   //////////////////////////////////////////////////////////////////////
   // Register numbers
   //////////////////////////////////////////////////////////////////////

   localparam rpRegSel_t regCs1 = 5'd0;   // Control
   localparam rpRegSel_t regDs  = 5'd1;   // Drive status
   localparam rpRegSel_t regDa  = 5'd5;   // Desired sector/track
   localparam rpRegSel_t regOf  = 5'd9;   // Offset
   localparam rpRegSel_t regDc  = 5'd10;  // Desired cylinder

   // Control register layout, GO in bit 0 and function above it
   localparam int csGoBit   = 0;
   localparam int csFuncLsb = 1;

   // Drive ready in the status register
   localparam int dsDryBit = 7;

   //////////////////////////////////////////////////////////////////////
   // Function codes
   //////////////////////////////////////////////////////////////////////

   localparam rpFunc_t funcSeek        = 5'd2;
   localparam rpFunc_t funcRecal       = 5'd3;
   localparam rpFunc_t funcDriveClear  = 5'd4;
   localparam rpFunc_t funcCenter      = 5'd7;
   localparam rpFunc_t funcPreset      = 5'd8;
   localparam rpFunc_t funcWrite       = 5'd24;
   localparam rpFunc_t funcWriteHeader = 5'd25;

   //////////////////////////////////////////////////////////////////////
   // Offset register fields
   //////////////////////////////////////////////////////////////////////

   localparam int ofFmt22Bit = 12;        // 16-bit format
   localparam int ofEciBit   = 11;        // ECC inhibit
   localparam int ofHciBit   = 10;        // Header compare inhibit
   localparam int ofOfdBit   = 7;         // Offset direction
   localparam int ofOfsLsb   = 0;         // Offset magnitude, bits 6..0
   localparam int ofOfsWidth = 7;
   localparam rpReg_t ofImplementedMask = 16'h1CFF;

   //////////////////////////////////////////////////////////////////////
   // Structs
   //////////////////////////////////////////////////////////////////////

   // Decoded commands, each a single-cycle strobe
   typedef struct packed {
      logic driveClear;
      logic center;
      logic preset;
      logic seek;
      logic recal;
      logic write;
      logic writeHeader;
   } rpCmd_t;

   // One Wishbone classic request, held by the master until ack
   typedef struct packed {
      logic      cyc;
      logic      stb;
      logic      we;
      rpRegSel_t adr;
      rpData_t   dat;
   } rpWbReq_t;

endpackage

`default_nettype wire

//--- design/rpWishboneSlave.sv
/*
   Wishbone classic slave, one ack per request and no wait states.
   Master must drop stb after ack. Unmapped registers read zero.
   datOut is valid only while ack is high.
*/

`timescale 1ns/1ns
`default_nettype none

module rpWishboneSlave (
   input  wire                clk,
   input  wire                rst,
   input  wire rpPkg::rpWbReq_t wbReq,
   output logic               ack,
   output rpPkg::rpData_t     datOut,
   output logic               ofWrite,
   output logic               goWrite,
   output rpPkg::rpFunc_t     func,
   output rpPkg::rpReg_t      wrData,
   input  wire                dry,
   input  wire rpPkg::rpReg_t ofValue
);

   logic          writeCycle;    // Write accepted on this edge
   rpPkg::rpFunc_t cs1Func;      // Stored function code
   rpPkg::rpReg_t daReg;         // Desired sector/track
   rpPkg::rpReg_t dcReg;         // Desired cylinder
   rpPkg::rpReg_t readValue;

   //////////////////////////////////////////////////////////////////////
   // Handshake
   //////////////////////////////////////////////////////////////////////

   // First cycle of cyc & stb, ack follows on the next edge
   assign writeCycle = wbReq.cyc & wbReq.stb & wbReq.we & ~ack;

   always_ff @(posedge clk)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= wbReq.cyc & wbReq.stb & ~ack;
   end

   //////////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////////

   // Registers only use the low half of the bus word
   assign wrData = wbReq.dat[rpPkg::regWidth-1:0];
   assign func   = wbReq.dat[rpPkg::csFuncLsb +: rpPkg::funcWidth];

   // Strobes to the offset register and command decoder
   assign ofWrite = writeCycle & (wbReq.adr == rpPkg::regOf);
   assign goWrite = writeCycle & (wbReq.adr == rpPkg::regCs1)
                    & wbReq.dat[rpPkg::csGoBit];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cs1Func <= '0;
         daReg   <= '0;
         dcReg   <= '0;
      end
      else if (writeCycle)
      begin
         // Function field frozen while the drive is busy
         if (wbReq.adr == rpPkg::regCs1 && dry)
            cs1Func <= func;
         if (wbReq.adr == rpPkg::regDa)
            daReg <= wrData;
         if (wbReq.adr == rpPkg::regDc)
            dcReg <= wrData;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      readValue = '0;
      case (wbReq.adr)
         rpPkg::regCs1:
         begin
            readValue[rpPkg::csFuncLsb +: rpPkg::funcWidth] = cs1Func;
            readValue[rpPkg::csGoBit] = ~dry;   // GO reads set while busy
         end
         rpPkg::regDs: readValue[rpPkg::dsDryBit] = dry;
         rpPkg::regDa: readValue = daReg;
         rpPkg::regOf: readValue = ofValue;
         rpPkg::regDc: readValue = dcReg;
         default:      readValue = '0;
      endcase
   end

   // Upper bus bits always zero
   assign datOut = {{(rpPkg::dataWidth - rpPkg::regWidth){1'b0}}, readValue};

endmodule

`default_nettype wire

//--- verification/rpDriveRegsAsserts.sv
/*
   Bus and offset readback assertions, bound into rpDriveRegs.
   failCount is read by the testbench for its closing report.
*/

`timescale 1ns/1ns
`default_nettype none

module rpDriveRegsAsserts (
   input wire                  clk,
   input wire                  rst,
   input wire rpPkg::rpWbReq_t wbReq,
   input wire                  ack,
   input wire rpPkg::rpData_t  datOut
);

   int failCount = 0;

   ////////////////////////////////////////////////////////////////////////
   // Wishbone handshake
   ////////////////////////////////////////////////////////////////////////

   // Ack only answers a live request
   ackNeedsRequest: assert property (@(posedge clk) disable iff (rst)
      ack |-> (wbReq.cyc && wbReq.stb))
   else
   begin
      failCount++;
      $error("ack seen without cyc and stb");
   end

   // One ack per request
   ackSingleCycle: assert property (@(posedge clk) disable iff (rst)
      ack |=> !ack)
   else
   begin
      failCount++;
      $error("ack high on two cycles in a row");
   end

   ////////////////////////////////////////////////////////////////////////
   // Data
   ////////////////////////////////////////////////////////////////////////

   upperBitsZero: assert property (@(posedge clk) disable iff (rst)
      datOut[rpPkg::dataWidth-1:rpPkg::regWidth] == '0)
   else
   begin
      failCount++;
      $error("datOut upper bits not zero");
   end

   // Offset reads never show unimplemented bits
   offsetMasked: assert property (@(posedge clk) disable iff (rst)
      (ack && wbReq.adr == rpPkg::regOf)
         |-> (datOut[rpPkg::regWidth-1:0] & ~rpPkg::ofImplementedMask) == '0)
   else
   begin
      failCount++;
      $error("offset readback shows unimplemented bits");
   end

endmodule

bind rpDriveRegs rpDriveRegsAsserts asserts_i (
   .clk     (clk),
   .rst     (rst),
   .wbReq   (wbReq),
   .ack     (ack),
   .datOut  (datOut)
);

`default_nettype wire

//--- verification/rpDriveRegsTb.sv
/*
   Testbench for the RP drive register block, seekTime 16.
   Bus inputs change 1 ns after the rising edge. Every wait is bounded.
   Offset expectations come from a small field-rule model.
*/

`timescale 1ns/1ns
`default_nettype none

module rpDriveRegsTb;

   localparam int seekTime     = 16;
   localparam int ackTimeout   = 20;    // Cycles to wait for ack
   localparam int readyTimeout = 50;    // Status reads before giving up
   // Offset direction and magnitude
   localparam rpPkg::rpReg_t ofsFields = (16'h1 << rpPkg::ofOfdBit) | 16'h007F;
   // Format and inhibit bits
   localparam rpPkg::rpReg_t fmtFields = (16'h1 << rpPkg::ofFmt22Bit)
                                         | (16'h1 << rpPkg::ofEciBit)
                                         | (16'h1 << rpPkg::ofHciBit);

   logic            clk;
   logic            rst;
   rpPkg::rpWbReq_t wbReq;
   logic            ack;
   rpPkg::rpData_t  datOut;

   // Reference model state
   rpPkg::rpReg_t   modelOf;
   rpPkg::rpFunc_t  modelFunc;
   logic            modelDry;
   logic [31:0]     rngState;
   int              checks;
   int              errors;
   int              timeouts;

   rpDriveRegs #(
      .seekTime (seekTime)
   ) dut_i (
      .clk    (clk),
      .rst    (rst),
      .wbReq  (wbReq),
      .ack    (ack),
      .datOut (datOut)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Closing report
   //////////////////////////////////////////////////////////////////////

   task automatic endRun();
      int assertFails;
      assertFails = dut_i.asserts_i.failCount;
      $display("Checks %0d, read errors %0d, assertion failures %0d, timeouts %0d",
               checks, errors, assertFails, timeouts);
      if (errors == 0 && assertFails == 0 && timeouts == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////////////////////////

   // One classic cycle, request held until ack is seen at an edge
   task automatic busAccess(input logic we, input rpPkg::rpRegSel_t adr,
                            input rpPkg::rpData_t dat, output rpPkg::rpData_t rdata);
      int waited;
      waited = 0;
      rdata  = '0;
      @(posedge clk);
      #1;
      wbReq.cyc = 1'b1;
      wbReq.stb = 1'b1;
      wbReq.we  = we;
      wbReq.adr = adr;
      wbReq.dat = dat;
      @(posedge clk);
      #1;
      while (!ack && waited < ackTimeout)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!ack)
      begin
         $display("No ack from register %0d within %0d cycles", adr, ackTimeout);
         timeouts++;
         endRun();
      end
      else
      begin
         rdata = datOut;
         // Master ends the cycle on the edge that samples ack
         @(posedge clk);
         #1;
         wbReq = '0;
      end
   endtask

   task automatic busWrite(input rpPkg::rpRegSel_t adr, input rpPkg::rpData_t dat);
      rpPkg::rpData_t unused;
      busAccess(1'b1, adr, dat, unused);
   endtask

   task automatic checkRead(input rpPkg::rpRegSel_t adr, input rpPkg::rpReg_t expected,
                            input string what);
      rpPkg::rpData_t got;
      busAccess(1'b0, adr, '0, got);
      checks++;
      // Full bus word compared, upper bits must be zero
      if (got !== rpPkg::rpData_t'(expected))
      begin
         errors++;
         $display("ERROR %0t: %s, register %0d read %h, expected %h",
                  $time, what, adr, got, rpPkg::rpData_t'(expected));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus and model helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic randomWord(output rpPkg::rpData_t w);
      logic [31:0] hi;
      rngState = xorshift32(rngState);
      hi       = rngState;
      rngState = xorshift32(rngState);
      w = {hi[3:0], rngState};
   endtask

   // Control readback, GO shown while busy
   function automatic rpPkg::rpReg_t cs1Expect();
      rpPkg::rpReg_t v;
      v = '0;
      v[rpPkg::csFuncLsb +: rpPkg::funcWidth] = modelFunc;
      v[rpPkg::csGoBit] = ~modelDry;
      return v;
   endfunction

   task automatic writeOffset(input rpPkg::rpData_t dat);
      busWrite(rpPkg::regOf, dat);
      if (modelDry)
         modelOf = dat[15:0] & rpPkg::ofImplementedMask;
   endtask

   task automatic issueCommand(input rpPkg::rpFunc_t code);
      rpPkg::rpData_t word;
      word = '0;
      word[rpPkg::csFuncLsb +: rpPkg::funcWidth] = code;
      word[rpPkg::csGoBit] = 1'b1;
      busWrite(rpPkg::regCs1, word);
      // Busy drive ignores the whole write
      if (modelDry)
      begin
         modelFunc = code;
         case (code)
            rpPkg::funcPreset:
               modelOf = modelOf & ~fmtFields;
            rpPkg::funcDriveClear:
               modelOf = modelOf & ~ofsFields;
            rpPkg::funcCenter, rpPkg::funcSeek, rpPkg::funcWrite, rpPkg::funcWriteHeader:
            begin
               modelOf  = modelOf & ~ofsFields;
               modelDry = 1'b0;
            end
            rpPkg::funcRecal:
               modelDry = 1'b0;
            default:
               modelDry = modelDry;
         endcase
      end
   endtask

   // Poll drive status until ready, bounded number of reads
   task automatic waitReady();
      rpPkg::rpData_t status;
      int polls;
      polls  = 0;
      status = '0;
      while (!status[rpPkg::dsDryBit] && polls < readyTimeout)
      begin
         busAccess(1'b0, rpPkg::regDs, '0, status);
         polls++;
      end
      if (!status[rpPkg::dsDryBit])
      begin
         $display("Drive never returned to ready after %0d status reads", polls);
         timeouts++;
         endRun();
      end
      else
      begin
         modelDry = 1'b1;
         checkRead(rpPkg::regDs, 16'h1 << rpPkg::dsDryBit, "status after busy");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      rpPkg::rpData_t w;
      wbReq     = '0;
      rst       = 1'b1;
      modelOf   = '0;
      modelFunc = '0;
      modelDry  = 1'b1;
      rngState  = 32'd24;
      checks    = 0;
      errors    = 0;
      timeouts  = 0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset values and an unmapped register
      checkRead(rpPkg::regCs1, 16'h0000, "control after reset");
      checkRead(rpPkg::regDs, 16'h1 << rpPkg::dsDryBit, "status after reset");
      checkRead(rpPkg::regDa, 16'h0000, "address after reset");
      checkRead(rpPkg::regOf, 16'h0000, "offset after reset");
      checkRead(rpPkg::regDc, 16'h0000, "cylinder after reset");
      checkRead(5'd3, 16'h0000, "unmapped register");
      checkRead(5'd31, 16'h0000, "unmapped register");

      // Random offset writes while ready
      for (int i = 0; i < 20; i++)
      begin
         randomWord(w);
         writeOffset(w);
         checkRead(rpPkg::regOf, modelOf, "random offset readback");
      end

      // Preset then drive clear on a full register
      writeOffset(36'hFFFF);
      issueCommand(rpPkg::funcPreset);
      checkRead(rpPkg::regOf, modelOf, "offset after preset");
      writeOffset(36'hFFFF);
      issueCommand(rpPkg::funcDriveClear);
      checkRead(rpPkg::regOf, modelOf, "offset after drive clear");

      // Seek, offset write while busy, then wait for ready
      writeOffset(36'h1C85);
      issueCommand(rpPkg::funcSeek);
      checkRead(rpPkg::regDs, 16'h0000, "status while seeking");
      checkRead(rpPkg::regCs1, cs1Expect(), "control while seeking");
      writeOffset(36'h0000);
      checkRead(rpPkg::regOf, modelOf, "offset written while busy");
      waitReady();
      checkRead(rpPkg::regOf, modelOf, "offset after seek");

      // Preset while busy keeps FMT22
      issueCommand(rpPkg::funcSeek);
      issueCommand(rpPkg::funcPreset);
      checkRead(rpPkg::regOf, modelOf, "offset after preset while busy");
      waitReady();

      // Write and write header
      writeOffset(36'h1CFF);
      issueCommand(rpPkg::funcWrite);
      checkRead(rpPkg::regOf, modelOf, "offset after write");
      waitReady();
      writeOffset(36'h10AA);
      issueCommand(rpPkg::funcWriteHeader);
      checkRead(rpPkg::regOf, modelOf, "offset after write header");
      waitReady();
      checkRead(rpPkg::regCs1, cs1Expect(), "control after write header");

      // Desired address and cylinder, upper bus bits dropped
      for (int i = 0; i < 10; i++)
      begin
         randomWord(w);
         busWrite(rpPkg::regDa, w);
         checkRead(rpPkg::regDa, w[15:0], "desired address");
         randomWord(w);
         busWrite(rpPkg::regDc, w);
         checkRead(rpPkg::regDc, w[15:0], "desired cylinder");
      end

      repeat (5) @(posedge clk);
      endRun();
   end

endmodule

`default_nettype wire

//--- vlog.f
design/rpPkg.sv
design/rpWishboneSlave.sv
design/rpCommandDecode.sv
design/rpOffsetReg.sv
design/rpDriveSequencer.sv
design/rpDriveRegs.sv
verification/rpDriveRegsAsserts.sv
verification/rpDriveRegsTb.sv
